//--- bench/clockGen.sv
`timescale 1ns/1ps
`default_nettype none

module clockGen #(
    parameter real halfPeriod  = 4.0, // ns, 8 ns period
    parameter int  resetCycles = 2    // Clock cycles with reset held
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(halfPeriod) clk = ~clk; // Free-running clock
    end

    initial begin
        rst = 1'b1; // Held from time zero
        repeat (resetCycles) @(negedge clk);
        rst = 1'b0; // Released on a falling edge
    end

endmodule

`default_nettype wire

//--- bench/motorCommandLinkTb.sv
`timescale 1ns/1ps
`default_nettype none

module motorCommandLinkTb;

    localparam int bitClks    = 8;    // Baud divisor for simulation
    localparam int doneLimit  = 4000; // Cycles allowed per message
    localparam int idleLimit  = 200;  // Longest quiet line between frames
    localparam int resetLimit = 10;
    localparam int randomRuns = 30;

    logic        clk;
    logic        rst;
    logic [2:0]  stateControl;
    logic        txLine;
    logic        done;
    logic [7:0]  messageLength;
    logic [7:0]  lastByte;

    int unsigned seed = 35;       // LCG state
    string       testName = "reset";
    int          errorCount = 0;
    int          testsPassed = 0;
    int          testsFailed = 0;
    int          msgCount = 0;    // Messages ended by a newline
    int          doneCount = 0;
    logic        sawStart = 1'b0; // First start bit seen
    logic        firstCycle;      // First cycle after reset
    logic        latchNow;        // DUT latches a message this cycle
    logic        lengthDue;       // messageLength valid for the new message
    logic [7:0]  latchedLen;
    logic [2:0]  latchQ [$];      // Drive state per latched message

    clockGen #(.halfPeriod(4.0), .resetCycles(2)) clocks (.clk(clk), .rst(rst));

    motorCommandLink #(.clksPerBit(bitClks)) uut (
        .clk          (clk),
        .rst          (rst),
        .stateControl (stateControl),
        .txLine       (txLine),
        .done         (done),
        .messageLength(messageLength),
        .lastByte     (lastByte)
    );

    // Wheel text from the drive table
    function automatic string wheelText(input logic [2:0] state, input bit right);
        case (state)
            3'd1: return right ? "0.12" : "-0.00"; // Turn left
            3'd2: return right ? "-0.00" : "0.12"; // Turn right
            3'd3: return "0.05";
            3'd4: return "0.25";
            3'd5: return "0.5";
            default: return "0"; // Stop, 6 and 7 too
        endcase
    endfunction

    // Message without its closing newline
    function automatic string expectedBody(input logic [2:0] state);
        return {"{\"T\":1,\"L\":", wheelText(state, 1'b0),
                ",\"R\":", wheelText(state, 1'b1), "}"};
    endfunction

    function automatic logic [2:0] nextState();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed[18:16]; // Upper bits, better spread
    endfunction

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            firstCycle <= 1'b1;
        end else begin
            firstCycle <= 1'b0;
        end
    end

    assign latchNow = firstCycle || done; // Same cycles the serializer latches

    // Tracks which state each message carries
    always @(posedge clk) begin
        if (rst) begin
            lengthDue <= 1'b0;
        end else begin
            lengthDue <= latchNow;
            if (latchNow) begin
                latchQ.push_back(stateControl);
                latchedLen <= 8'(expectedBody(stateControl).len() + 1); // Plus newline
            end
            if (done) begin
                doneCount++;
                assert (doneCount == msgCount) else begin
                    errorCount++;
                    $display("error: test %s done count expected %0d actual %0d",
                             testName, msgCount, doneCount);
                end
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst) !sawStart |-> txLine && !done)
        else begin
            errorCount++;
            $display("txLine low or done high before the first start bit in test %s",
                     testName);
        end

    assert property (@(posedge clk) disable iff (rst) firstCycle |-> messageLength == 8'd20)
        else begin
            errorCount++;
            $display("error: test %s reset length expected 20 actual %0d",
                     testName, messageLength);
        end

    assert property (@(posedge clk) disable iff (rst)
        lengthDue |-> messageLength == latchedLen)
        else begin
            errorCount++;
            $display("error: test %s messageLength expected %0d actual %0d",
                     testName, latchedLen, messageLength);
        end

    assert property (@(posedge clk) disable iff (rst) done |-> lastByte == 8'h0A)
        else begin
            errorCount++;
            $display("error: test %s lastByte expected 0a actual %h", testName, lastByte);
        end

    assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else begin
            errorCount++;
            $display("done stayed high for more than one cycle in test %s", testName);
        end

    // UART receiver, samples at bit centers on falling edges
    initial begin : receiver
        logic [7:0] rxByte;
        string      rxText;
        string      want;
        logic [2:0] state;
        int         quiet;
        rxText = "";
        forever begin
            quiet = 0;
            @(negedge clk);
            while (rst || txLine) begin // Hunt for a start bit
                quiet++;
                if (quiet > idleLimit) begin
                    $display("txLine stayed idle too long in test %s", testName);
                    $display("Result: FAILED");
                    $finish;
                end
                @(negedge clk);
            end
            sawStart = 1'b1;
            repeat (bitClks / 2 - 1) @(negedge clk); // Middle of the start bit
            assert (txLine == 1'b0) else begin
                errorCount++;
                $display("start bit did not stay low in test %s", testName);
            end
            for (int i = 0; i < 8; i++) begin
                repeat (bitClks) @(negedge clk);
                rxByte[i] = txLine; // LSB first
            end
            repeat (bitClks) @(negedge clk);
            assert (txLine == 1'b1) else begin
                errorCount++;
                $display("stop bit was low in test %s", testName);
            end
            if (rxByte == 8'h0A) begin // Newline ends a message
                msgCount++;
                if (latchQ.size() == 0) begin
                    errorCount++;
                    $display("message arrived with no latched drive state in test %s",
                             testName);
                end else begin
                    state = latchQ.pop_front();
                    want  = expectedBody(state);
                    assert (rxText == want) else begin
                        errorCount++;
                        $display("error: test %s message expected %s actual %s",
                                 testName, want, rxText);
                    end
                end
                rxText = "";
            end else begin
                rxText = $sformatf("%s%c", rxText, rxByte);
            end
        end
    end

    task automatic waitDone(input int count);
        int cycles;
        for (int n = 0; n < count; n++) begin
            cycles = 0;
            do begin
                @(negedge clk);
                cycles++;
                if (cycles > doneLimit) begin
                    $display("no done pulse within %0d cycles in test %s",
                             doneLimit, testName);
                    $display("Result: FAILED");
                    $finish;
                end
            end while (!done);
        end
    endtask

    task automatic finishTest(input int errorsBefore);
        if (errorCount == errorsBefore) begin
            testsPassed++;
            $display("test %s passed", testName);
        end else begin
            testsFailed++;
            $display("test %s failed with %0d errors", testName, errorCount - errorsBefore);
        end
    endtask

    initial begin : stimulus
        int errorsBefore;
        int cycles;
        stateControl = 3'd0;
        cycles       = 0;
        errorsBefore = 0;
        @(negedge clk);
        while (rst) begin
            cycles++;
            if (cycles > resetLimit) begin
                $display("reset was never released");
                $display("Result: FAILED");
                $finish;
            end
            @(negedge clk);
        end
        waitDone(1); // First message, stop state
        finishTest(errorsBefore);

        // New state set right after done reaches the next latch
        for (int s = 0; s < 8; s++) begin
            testName     = $sformatf("state%0d", s);
            errorsBefore = errorCount;
            stateControl = 3'(s);
            waitDone(1);
            finishTest(errorsBefore);
        end

        testName     = "midMessage";
        errorsBefore = errorCount;
        stateControl = 3'd1;
        repeat (300) @(negedge clk); // Well inside the left-turn message
        stateControl = 3'd5;
        waitDone(2); // Left turn intact, then fast
        finishTest(errorsBefore);

        testName     = "random";
        errorsBefore = errorCount;
        for (int r = 0; r < randomRuns; r++) begin
            stateControl = nextState();
            waitDone(1);
        end
        finishTest(errorsBefore);

        $display("%0d tests passed, %0d tests failed, %0d check errors",
                 testsPassed, testsFailed, errorCount);
        if (errorCount == 0 && testsFailed == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+source
source/motorLinkPkg.sv
source/commandDecoder.sv
source/wheelFieldFormatter.sv
source/messageSerializer.sv
source/uartTransmitter.sv
source/motorCommandLink.sv
bench/clockGen.sv
bench/motorCommandLinkTb.sv

//--- source/commandDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module commandDecoder (
    input  logic [2:0]               stateControl, // Drive state from the switches
    output motorLinkPkg::wheelCommand command      // Speed code per wheel
);

    always_comb begin
        case (stateControl)
            3'd0: begin // Stop
                command.left  = motorLinkPkg::spdZero;
                command.right = motorLinkPkg::spdZero;
            end
            3'd1: begin // Turn left
                command.left  = motorLinkPkg::spdNegZero;
                command.right = motorLinkPkg::spdTurn;
            end
            3'd2: begin // Turn right
                command.left  = motorLinkPkg::spdTurn;
                command.right = motorLinkPkg::spdNegZero;
            end
            3'd3: begin // Forward slow
                command.left  = motorLinkPkg::spdSlow;
                command.right = motorLinkPkg::spdSlow;
            end
            3'd4: begin // Forward medium
                command.left  = motorLinkPkg::spdMedium;
                command.right = motorLinkPkg::spdMedium;
            end
            3'd5: begin // Forward fast
                command.left  = motorLinkPkg::spdFast;
                command.right = motorLinkPkg::spdFast;
            end
            default: begin // Codes 6 and 7 stop the robot
                command.left  = motorLinkPkg::spdZero;
                command.right = motorLinkPkg::spdZero;
            end
        endcase
    end

    // Floating switch inputs would silently map to stop
    assert final (!$isunknown(stateControl))
        else $error("commandDecoder: stateControl is unknown");

endmodule

`default_nettype wire

//--- source/linkParams.svh
`ifndef LINK_PARAMS_SVH
`define LINK_PARAMS_SVH

// Shared sizing for the motor command link

// Baud divisor for 115200 baud on a 50 MHz clock
`define LINK_CLKS_PER_BIT 434

// Longest wheel field text, as in "-0.00"
`define LINK_FIELD_CHARS 5

// Differential drive, left and right
`define LINK_WHEELS 2

// Fixed skeleton plus the two longest fields
`define LINK_MAX_MSG 27

`endif

//--- source/messageSerializer.sv
`timescale 1ns/1ps
`default_nettype none

`include "linkParams.svh"

module messageSerializer (
    input  logic                    clk,
    input  logic                    rst,
    input  motorLinkPkg::wheelField fields [`LINK_WHEELS], // Left then right
    output logic [7:0]              byteData,      // Byte offered to the UART
    output logic                    byteValid,     // Offer pending
    input  logic                    byteReady,     // UART idle
    input  logic                    frameEnd,      // Stop bit finishing
    output logic                    done,          // Message fully on the line
    output logic [7:0]              messageLength, // Length of latched message
    output logic [7:0]              lastByte       // Most recently accepted byte
);

    localparam int prefixLen  = 11;
    localparam int midLen     = 5;
    localparam int suffixLen  = 2;
    localparam int fixedChars = prefixLen + midLen + suffixLen; // 18 skeleton bytes

    localparam logic [8*prefixLen-1:0] prefixText = "{\"T\":1,\"L\":";
    localparam logic [8*midLen-1:0]    midText    = ",\"R\":";
    localparam logic [8*suffixLen-1:0] suffixText = "}\n";

    typedef enum logic [2:0] {
        segLatch,   // Capture fields for the next message
        segPrefix,  // {"T":1,"L":
        segLeft,    // Left wheel text
        segMid,     // ,"R":
        segRight,   // Right wheel text
        segSuffix,  // Closing brace and newline
        segWaitEnd  // Last frame still on the line
    } segmentType;

    segmentType              segment;      // Segment of the byte on byteData
    segmentType              nextSegment;  // Segment after the current one
    logic [3:0]              charIndex;    // Char within the segment
    logic                    segmentLast;  // Current byte ends its segment
    logic                    transfer;     // Handshake completes this cycle
    motorLinkPkg::wheelField held [`LINK_WHEELS]; // Fields frozen per message

    assign transfer = byteValid && byteReady;

    // Byte lookup from the segment cursor
    always_comb begin
        byteData    = 8'h00;
        segmentLast = 1'b0;
        nextSegment = segLatch;
        case (segment)
            segPrefix: begin
                byteData    = prefixText[8*(prefixLen-1-charIndex) +: 8];
                segmentLast = charIndex == 4'(prefixLen - 1);
                nextSegment = segLeft;
            end
            segLeft: begin
                byteData    = held[0].chars[`LINK_FIELD_CHARS-1-charIndex];
                segmentLast = charIndex == {1'b0, held[0].length} - 4'd1; // Latched length
                nextSegment = segMid;
            end
            segMid: begin
                byteData    = midText[8*(midLen-1-charIndex) +: 8];
                segmentLast = charIndex == 4'(midLen - 1);
                nextSegment = segRight;
            end
            segRight: begin
                byteData    = held[1].chars[`LINK_FIELD_CHARS-1-charIndex];
                segmentLast = charIndex == {1'b0, held[1].length} - 4'd1;
                nextSegment = segSuffix;
            end
            segSuffix: begin
                byteData    = suffixText[8*(suffixLen-1-charIndex) +: 8];
                segmentLast = charIndex == 4'(suffixLen - 1);
                nextSegment = segWaitEnd;
            end
            default: begin // Latch and wait present no byte
                nextSegment = segLatch;
            end
        endcase
    end

    // Segment FSM and handshake
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            segment       <= segLatch;
            charIndex     <= '0;
            byteValid     <= 1'b0;
            done          <= 1'b0;
            messageLength <= 8'(fixedChars + 2); // Stop message
            lastByte      <= 8'h00;
        end else begin
            done <= 1'b0; // Single-cycle pulse
            if (segment == segLatch) begin
                segment       <= segPrefix;
                charIndex     <= '0;
                byteValid     <= 1'b1; // First brace offered next cycle
                messageLength <= 8'(fixedChars) + 8'(fields[0].length) + 8'(fields[1].length);
            end else if (segment == segWaitEnd) begin
                if (frameEnd) begin // Newline frame finished
                    done    <= 1'b1;
                    segment <= segLatch; // Next message latched with done
                end
            end else if (transfer) begin
                lastByte <= byteData;
                if (segmentLast) begin
                    segment   <= nextSegment;
                    charIndex <= '0;
                    if (segment == segSuffix) begin
                        byteValid <= 1'b0; // Newline was the last byte
                    end
                end else begin
                    charIndex <= charIndex + 4'd1;
                end
            end
        end
    end

    // Field payload, captured once per message
    always_ff @(posedge clk) begin
        if (segment == segLatch) begin
            held <= fields;
        end
    end

    // Offered byte holds until the UART takes it
    assert property (@(posedge clk) disable iff (rst)
        byteValid && !byteReady |=> byteValid && $stable(byteData))
        else $error("messageSerializer: byte changed before transfer");

    // done only after the whole message has left
    assert property (@(posedge clk) disable iff (rst) !(done && byteValid))
        else $error("messageSerializer: done while a byte is pending");

    assert property (@(posedge clk) disable iff (rst) messageLength <= 8'(`LINK_MAX_MSG))
        else $error("messageSerializer: length %0d over limit", messageLength);

endmodule

`default_nettype wire

//--- source/motorCommandLink.sv
`timescale 1ns/1ps
`default_nettype none

`include "linkParams.svh"

module motorCommandLink #(
    parameter int clksPerBit = `LINK_CLKS_PER_BIT // Baud divisor
) (
    input  logic       clk,
    input  logic       rst,
    input  logic [2:0] stateControl,  // Drive state select
    output logic       txLine,        // UART output to the motor board
    output logic       done,          // Message complete pulse
    output logic [7:0] messageLength, // Bytes in the current message
    output logic [7:0] lastByte       // Last byte handed to the UART
);

    motorLinkPkg::wheelCommand command;                    // Decoded speeds
    motorLinkPkg::speedCode    wheelSpeeds [`LINK_WHEELS]; // Speed per wheel
    motorLinkPkg::wheelField   fields [`LINK_WHEELS];      // Text per wheel
    logic [7:0]                byteData;
    logic                      byteValid;
    logic                      byteReady;
    logic                      frameEnd;

    commandDecoder decoder (
        .stateControl(stateControl),
        .command     (command)
    );

    assign wheelSpeeds[0] = command.left;
    assign wheelSpeeds[1] = command.right;

    // One formatter per wheel
    for (genvar w = 0; w < `LINK_WHEELS; w++) begin : gWheel
        wheelFieldFormatter formatter (
            .speed(wheelSpeeds[w]),
            .field(fields[w])
        );
    end

    messageSerializer serializer (
        .clk          (clk),
        .rst          (rst),
        .fields       (fields),
        .byteData     (byteData),
        .byteValid    (byteValid),
        .byteReady    (byteReady),
        .frameEnd     (frameEnd),
        .done         (done),
        .messageLength(messageLength),
        .lastByte     (lastByte)
    );

    uartTransmitter #(.clksPerBit(clksPerBit)) transmitter (
        .clk      (clk),
        .rst      (rst),
        .byteData (byteData),
        .byteValid(byteValid),
        .byteReady(byteReady),
        .txLine   (txLine),
        .frameEnd (frameEnd)
    );

endmodule

`default_nettype wire

//--- source/motorLinkPkg.sv
`default_nettype none

`include "linkParams.svh"

package motorLinkPkg;

    // Speed text selector per wheel
    typedef enum logic [2:0] {
        spdZero    = 3'd0, // "0"
        spdNegZero = 3'd1, // "-0.00"
        spdTurn    = 3'd2, // "0.12"
        spdSlow    = 3'd3, // "0.05"
        spdMedium  = 3'd4, // "0.25"
        spdFast    = 3'd5  // "0.5"
    } speedCode;

    // One speed code per wheel, left in the upper bits
    typedef struct packed {
        speedCode left;  // Goes after "L":
        speedCode right; // Goes after "R":
    } wheelCommand;

    // ASCII text of one wheel field
    typedef struct packed {
        logic [`LINK_FIELD_CHARS-1:0][7:0] chars; // First char in top byte
        logic [2:0]                        length; // Valid chars, 1 to 5
    } wheelField;

endpackage

`default_nettype wire

//--- source/uartTransmitter.sv
`timescale 1ns/1ps
`default_nettype none

`include "linkParams.svh"

module uartTransmitter #(
    parameter int clksPerBit = `LINK_CLKS_PER_BIT // Clock cycles per serial bit
) (
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] byteData,  // Byte to send
    input  logic       byteValid, // Byte offered
    output logic       byteReady, // High only while idle
    output logic       txLine,    // Serial output, idles high
    output logic       frameEnd   // Last cycle of the stop bit
);

    localparam int countWidth = (clksPerBit > 1) ? $clog2(clksPerBit) : 1;

    typedef enum logic [1:0] {
        txIdle,  // Line high, accepting a byte
        txStart, // Start bit low
        txData,  // Eight data bits, LSB first
        txStop   // Stop bit high
    } txStateType;

    txStateType            state;
    logic [countWidth-1:0] baudCount; // Cycles within the current bit
    logic [2:0]            bitCount;  // Data bit number
    logic [7:0]            shiftReg;  // Remaining data bits
    logic                  bitDone;   // Current bit has lasted clksPerBit

    assign bitDone   = baudCount == countWidth'(clksPerBit - 1);
    assign byteReady = state == txIdle;
    assign frameEnd  = (state == txStop) && bitDone;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= txIdle;
            baudCount <= '0;
            bitCount  <= '0;
            txLine    <= 1'b1; // Mark level
        end else begin
            baudCount <= bitDone ? '0 : baudCount + 1'b1;
            case (state)
                txIdle: begin
                    baudCount <= '0; // Bit timing starts at the start bit
                    if (byteValid) begin
                        state  <= txStart;
                        txLine <= 1'b0; // Start bit on the cycle after transfer
                    end
                end
                txStart: begin
                    if (bitDone) begin
                        state    <= txData;
                        bitCount <= '0;
                        txLine   <= shiftReg[0]; // Bit 0 first
                    end
                end
                txData: begin
                    if (bitDone) begin
                        if (bitCount == 3'd7) begin
                            state  <= txStop;
                            txLine <= 1'b1;
                        end else begin
                            bitCount <= bitCount + 3'd1;
                            txLine   <= shiftReg[0];
                        end
                    end
                end
                default: begin // Stop bit
                    if (bitDone) begin
                        state <= txIdle;
                    end
                end
            endcase
        end
    end

    // Data path, loaded on transfer and shifted per bit
    always_ff @(posedge clk) begin
        if (byteReady && byteValid) begin
            shiftReg <= byteData;
        end else if ((state == txStart || state == txData) && bitDone) begin
            shiftReg <= shiftReg >> 1;
        end
    end

    // Idle line must sit at mark between frames
    assert property (@(posedge clk) disable iff (rst) byteReady |-> txLine)
        else $error("uartTransmitter: line low while idle");

endmodule

`default_nettype wire

//--- source/wheelFieldFormatter.sv
`timescale 1ns/1ps
`default_nettype none

module wheelFieldFormatter (
    input  motorLinkPkg::speedCode  speed, // Speed code for this wheel
    output motorLinkPkg::wheelField field  // Left-aligned text and its length
);

    // Text is left-aligned, unused bytes padded with zero
    always_comb begin
        case (speed)
            motorLinkPkg::spdZero: begin
                field.chars  = {"0", 32'h0}; // Single digit
                field.length = 3'd1;
            end
            motorLinkPkg::spdNegZero: begin
                field.chars  = "-0.00"; // Fills all five bytes
                field.length = 3'd5;
            end
            motorLinkPkg::spdTurn: begin
                field.chars  = {"0.12", 8'h0}; // Turning wheel
                field.length = 3'd4;
            end
            motorLinkPkg::spdSlow: begin
                field.chars  = {"0.05", 8'h0};
                field.length = 3'd4;
            end
            motorLinkPkg::spdMedium: begin
                field.chars  = {"0.25", 8'h0};
                field.length = 3'd4;
            end
            motorLinkPkg::spdFast: begin
                field.chars  = {"0.5", 16'h0}; // Shortest nonzero speed text
                field.length = 3'd3;
            end
            default: begin // Unused codes send zero speed
                field.chars  = {"0", 32'h0};
                field.length = 3'd1;
            end
        endcase
    end

    // Serializer walks chars up to length, so an empty field would
    // end its segment before the first byte
    assert final (field.length != 3'd0)
        else $error("wheelFieldFormatter: empty field for speed %0d", speed);

endmodule

`default_nettype wire
